/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = execTb
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "tests failed" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -qx "all tests passed" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* aluCore.sv */
`timescale 1ns/1ps
`default_nettype none

module aluCore import mipsExecPkg::*; (
    input  logic [4:0]  aluOp,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result
);

    logic [31:0] sum;
    logic [31:0] diff;
    logic [4:0]  shiftAmount;
    logic        signedLess;
    logic        unsignedLess;

    assign sum = a + b;
    assign diff = a - b;

    // shifts move b by the low five bits of a
    assign shiftAmount = a[4:0];

    assign signedLess = $signed(a) < $signed(b);
    assign unsignedLess = a < b;

    always_comb begin
        case (aluOp)
            aluAnd: begin
                result = a & b;
            end
            aluOr: begin
                result = a | b;
            end
            aluXor: begin
                result = a ^ b;
            end
            aluAdd: begin
                result = sum;
            end
            aluSub: begin
                result = diff;
            end
            aluSlt: begin
                result = {31'd0, signedLess};
            end
            aluSltu: begin
                result = {31'd0, unsignedLess};
            end
            aluSll: begin
                result = b << shiftAmount;
            end
            aluSrl: begin
                result = b >> shiftAmount;
            end
            aluSra: begin
                // sign bit fills from the left
                result = $signed(b) >>> shiftAmount;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* divider.sv */
`timescale 1ns/1ps
`default_nettype none

module divider import mipsExecPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        req,
    output logic        ack,
    input  mdOperands_t operands,
    output mdResult_t   quotient
);

    typedef enum logic [1:0] {divIdle, divRun, divFix, divDone} divState_t;

    divState_t   state;
    logic [4:0]  count;
    logic [31:0] magB;
    logic [31:0] rem;
    logic [31:0] quo;
    logic        negQ;
    logic        negR;
    logic        divZero;
    logic [32:0] shifted;
    logic [32:0] trial;

    // restoring step, borrow in the top bit means the divisor did not fit
    assign shifted = {rem, quo[31]};
    assign trial = shifted - {1'b0, magB};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= divIdle;
            count <= '0;
            ack <= 1'b0;
        end else begin
            case (state)
                divIdle: begin
                    if (req && !ack) begin
                        state <= divRun;
                        count <= '0;
                    end
                end
                divRun: begin
                    count <= count + 5'd1;
                    if (count == 5'd31) begin
                        state <= divFix;
                    end
                end
                divFix: begin
                    state <= divDone;
                end
                default: begin
                    // ack follows the corrected result by one cycle
                    if (!ack) begin
                        ack <= 1'b1;
                    end else if (!req) begin
                        state <= divIdle;
                        ack <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == divIdle && req && !ack) begin
            quo <= (operands.isSigned && operands.srcA[31]) ? -operands.srcA : operands.srcA;
            magB <= (operands.isSigned && operands.srcB[31]) ? -operands.srcB : operands.srcB;
            rem <= '0;
            negQ <= operands.isSigned && (operands.srcA[31] ^ operands.srcB[31]);
            negR <= operands.isSigned && operands.srcA[31];
            divZero <= operands.srcB == 32'd0;
        end else if (state == divRun) begin
            rem <= trial[32] ? shifted[31:0] : trial[31:0];
            quo <= {quo[30:0], ~trial[32]};
        end else if (state == divFix) begin
            if (divZero) begin
                // operands are still held stable by the sequencer here
                quotient.lo <= '1;
                quotient.hi <= operands.srcA;
            end else begin
                // most negative over minus one lands on 0x80000000 with no fixup
                quotient.lo <= negQ ? -quo : quo;
                quotient.hi <= negR ? -rem : rem;
            end
        end
    end

endmodule

`default_nettype wire

/* execChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module execChecker import mipsExecPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  execReq_t    req,
    input  logic [31:0] out,
    input  logic        stall,
    output int          errorCount,
    output int          checkCount
);

    // engines take at least 33 cycles before ack
    localparam int minStallCycles = 33;

    logic [31:0] hiModel;
    logic [31:0] loModel;
    int          stallCycles;
    logic        inReset;

    function automatic logic [31:0] aluRef(input logic [4:0] op, input logic [31:0] a,
                                           input logic [31:0] b);
        logic [4:0] s;
        s = a[4:0];
        case (op)
            aluAnd:  return a & b;
            aluOr:   return a | b;
            aluXor:  return a ^ b;
            aluAdd:  return a + b;
            aluSub:  return a + ~b + 32'd1;
            // flipping the sign bits turns a signed compare into an unsigned one
            aluSlt:  return ((a ^ 32'h80000000) < (b ^ 32'h80000000)) ? 32'd1 : 32'd0;
            aluSltu: return (a < b) ? 32'd1 : 32'd0;
            aluSll:  return b << s;
            aluSrl:  return b >> s;
            aluSra:  return (b >> s) | (b[31] ? ~(32'hffffffff >> s) : 32'd0);
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] refResult(input execReq_t r, input logic [31:0] hiM,
                                              input logic [31:0] loM);
        logic [31:0] shamtA;
        shamtA = {27'd0, r.shamt};
        if (r.aluControl != aluRType) begin
            return aluRef(r.aluControl, r.srcA, r.srcB);
        end
        case (r.funct)
            fnSll:   return aluRef(aluSll, shamtA, r.srcB);
            fnSrl:   return aluRef(aluSrl, shamtA, r.srcB);
            fnSra:   return aluRef(aluSra, shamtA, r.srcB);
            fnSllv:  return aluRef(aluSll, r.srcA, r.srcB);
            fnSrlv:  return aluRef(aluSrl, r.srcA, r.srcB);
            fnSrav:  return aluRef(aluSra, r.srcA, r.srcB);
            fnAddu:  return aluRef(aluAdd, r.srcA, r.srcB);
            fnSubu:  return aluRef(aluSub, r.srcA, r.srcB);
            fnAnd:   return aluRef(aluAnd, r.srcA, r.srcB);
            fnOr:    return aluRef(aluOr, r.srcA, r.srcB);
            fnXor:   return aluRef(aluXor, r.srcA, r.srcB);
            fnSlt:   return aluRef(aluSlt, r.srcA, r.srcB);
            fnSltu:  return aluRef(aluSltu, r.srcA, r.srcB);
            fnMfhi:  return hiM;
            fnMflo:  return loM;
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic isMulDiv(input execReq_t r);
        return r.aluControl == aluRType && (r.funct == fnMult || r.funct == fnMultu ||
                                            r.funct == fnDiv || r.funct == fnDivu);
    endfunction

    task automatic updateModel(input execReq_t r);
        logic [63:0]        prod;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = r.srcA;
        sb = r.srcB;
        if (r.aluControl == aluRType) begin
            case (r.funct)
                fnMthi: hiModel = r.srcA;
                fnMtlo: loModel = r.srcA;
                fnMult: begin
                    prod = $signed({{32{r.srcA[31]}}, r.srcA}) *
                           $signed({{32{r.srcB[31]}}, r.srcB});
                    {hiModel, loModel} = prod;
                end
                fnMultu: begin
                    prod = {32'd0, r.srcA} * {32'd0, r.srcB};
                    {hiModel, loModel} = prod;
                end
                fnDiv, fnDivu: begin
                    if (r.srcB == 32'd0) begin
                        loModel = 32'hffffffff;
                        hiModel = r.srcA;
                    end else if (r.funct == fnDivu) begin
                        loModel = r.srcA / r.srcB;
                        hiModel = r.srcA % r.srcB;
                    end else if (r.srcA == 32'h80000000 && r.srcB == 32'hffffffff) begin
                        loModel = 32'h80000000;
                        hiModel = 32'd0;
                    end else begin
                        loModel = sa / sb;
                        hiModel = sa % sb;
                    end
                end
                default: begin
                end
            endcase
        end
    endtask

    // a rising edge with stall low completes the request on the inputs
    always @(posedge clk) begin
        logic [31:0] expected;
        if (reset) begin
            hiModel = '0;
            loModel = '0;
            stallCycles = 0;
            inReset = 1'b1;
            errorCount = 0;
            checkCount = 0;
        end else begin
            if (inReset && stall) begin
                errorCount = errorCount + 1;
                $display("stall was high in the first cycle after reset at %0t", $time);
            end
            inReset = 1'b0;
            if (stall) begin
                stallCycles = stallCycles + 1;
            end else begin
                expected = refResult(req, hiModel, loModel);
                checkCount = checkCount + 1;
                if (out !== expected) begin
                    errorCount = errorCount + 1;
                    $display("[FAIL] %0t: ctrl %0d funct %02h srcA %08h srcB %08h out %08h, want %08h",
                             $time, req.aluControl, req.funct, req.srcA, req.srcB, out, expected);
                end
                if (isMulDiv(req) && stallCycles < minStallCycles) begin
                    errorCount = errorCount + 1;
                    $display("multiply or divide at %0t finished after only %0d stall cycles",
                             $time, stallCycles);
                end else if (!isMulDiv(req) && stallCycles != 0) begin
                    errorCount = errorCount + 1;
                    $display("request at %0t stalled although it is not a multiply or divide",
                             $time);
                end
                updateModel(req);
                stallCycles = 0;
            end
        end
    end

endmodule

`default_nettype wire

/* execTb.sv */
`timescale 1ns/1ps
`default_nettype none

module execTb import mipsExecPkg::*; ();

    localparam logic [31:0] seedInit = 32'd76231;
    localparam int numInstr = 300;
    localparam int timeoutLimit = numInstr * 40 + 200;

    logic        clk;
    logic        reset;
    execReq_t    req;
    logic [31:0] out;
    logic        stall;
    logic [31:0] lcgState;
    int          issued;
    int          cycleCount;
    int          errorCount;
    int          checkCount;

    always #10 clk = ~clk;

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // R-type functions the random stream draws from, last slot is an unknown code
    function automatic logic [5:0] functFor(input logic [4:0] idx);
        case (idx)
            5'd0:  return fnSll;
            5'd1:  return fnSrl;
            5'd2:  return fnSra;
            5'd3:  return fnSllv;
            5'd4:  return fnSrlv;
            5'd5:  return fnSrav;
            5'd6:  return fnMfhi;
            5'd7:  return fnMthi;
            5'd8:  return fnMflo;
            5'd9:  return fnMtlo;
            5'd10: return fnMult;
            5'd11: return fnMultu;
            5'd12: return fnDiv;
            5'd13: return fnDivu;
            5'd14: return fnAddu;
            5'd15: return fnSubu;
            5'd16: return fnAnd;
            5'd17: return fnOr;
            5'd18: return fnXor;
            5'd19: return fnSlt;
            5'd20: return fnSltu;
            default: return 6'h3f;
        endcase
    endfunction

    // one operand in four is a sign-boundary value
    task automatic drawOperand(output logic [31:0] v);
        lcgState = lcgNext(lcgState);
        if (lcgState[31:30] == 2'b00) begin
            case (lcgState[29:27])
                3'd0: v = 32'h00000000;
                3'd1: v = 32'h00000001;
                3'd2: v = 32'h7fffffff;
                3'd3: v = 32'h80000000;
                3'd4: v = 32'hffffffff;
                3'd5: v = 32'h80000001;
                3'd6: v = 32'hfffffffe;
                default: v = 32'h0000001f;
            endcase
        end else begin
            v = {lcgState[15:0], lcgState[31:16]};
        end
    endtask

    // drive on the falling edge, then hold until a rising edge sees stall low
    task automatic runInstr(input logic [4:0] ctrl, input logic [5:0] fn,
                            input logic [4:0] sh, input logic [31:0] a, input logic [31:0] b);
        @(negedge clk);
        req.aluControl = ctrl;
        req.funct = fn;
        req.shamt = sh;
        req.srcA = a;
        req.srcB = b;
        issued = issued + 1;
        @(posedge clk);
        while (stall) begin
            @(posedge clk);
        end
    endtask

    task automatic rType(input logic [5:0] fn, input logic [31:0] a, input logic [31:0] b);
        runInstr(aluRType, fn, 5'd0, a, b);
    endtask

    task automatic readHiLo();
        rType(fnMfhi, 32'd0, 32'd0);
        rType(fnMflo, 32'd0, 32'd0);
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  pick;
        logic [5:0]  fn;
        clk = 1'b0;
        reset = 1'b1;
        req = '0;
        lcgState = seedInit;
        issued = 0;
        cycleCount = 0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        readHiLo();
        rType(fnMthi, 32'h12345678, 32'd0);
        rType(fnMtlo, 32'h9abcdef0, 32'd0);
        readHiLo();
        rType(fnMult, 32'hfffffff9, 32'h00000003);
        readHiLo();
        rType(fnMultu, 32'hffffffff, 32'hffffffff);
        readHiLo();
        rType(fnDiv, 32'h80000000, 32'hffffffff);
        readHiLo();
        rType(fnDivu, 32'd1234, 32'd0);
        readHiLo();
        rType(fnDiv, 32'hfffffff0, 32'd0);
        readHiLo();
        // two divides back to back
        rType(fnDivu, 32'hffffffff, 32'd10);
        rType(fnDiv, 32'hffffff9c, 32'd7);
        readHiLo();
        runInstr(aluRType, fnSra, 5'd4, 32'd0, 32'h80000010);
        runInstr(aluRType, fnSll, 5'd31, 32'd0, 32'h00000003);
        runInstr(aluRType, fnSrl, 5'd1, 32'd0, 32'h80000000);
        while (issued < numInstr) begin
            drawOperand(a);
            drawOperand(b);
            lcgState = lcgNext(lcgState);
            pick = lcgState[28:24];
            if (pick < 5'd10) begin
                runInstr(pick, 6'd0, lcgState[20:16], a, b);
            end else begin
                fn = functFor(pick - 5'd10);
                runInstr(aluRType, fn, lcgState[20:16], a, b);
                if (fn == fnMult || fn == fnMultu || fn == fnDiv || fn == fnDivu) begin
                    readHiLo();
                end
            end
        end
        @(negedge clk);
        $display("closing report: %0d errors in %0d checks", errorCount, checkCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= timeoutLimit) begin
            $display("timeout: the run did not finish within %0d cycles", timeoutLimit);
            $display("closing report: %0d errors in %0d checks", errorCount, checkCount);
            $display("tests failed");
            $finish;
        end
    end

    execUnit UUT (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .out   (out),
        .stall (stall)
    );

    execChecker outCheck (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .out        (out),
        .stall      (stall),
        .errorCount (errorCount),
        .checkCount (checkCount)
    );

endmodule

`default_nettype wire

/* execUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module execUnit import mipsExecPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  execReq_t    req,
    output logic [31:0] out,
    output logic        stall
);

    typedef enum logic [1:0] {selAlu, selHi, selLo, selZero} outSel_t;

    outSel_t     outSel;
    logic [4:0]  aluOp;
    logic [31:0] aluA;
    logic [31:0] aluResult;
    logic [31:0] shamtExt;
    logic [31:0] hi;
    logic [31:0] lo;
    mdCmd_t      mdCmd;

    // fixed shifts take their amount from the instruction
    assign shamtExt = {27'd0, req.shamt};

    always_comb begin
        aluOp = req.aluControl;
        aluA = req.srcA;
        mdCmd = mdNone;
        outSel = selAlu;
        if (req.aluControl == aluRType) begin
            case (req.funct)
                fnSll: begin
                    aluOp = aluSll;
                    aluA = shamtExt;
                end
                fnSrl: begin
                    aluOp = aluSrl;
                    aluA = shamtExt;
                end
                fnSra: begin
                    aluOp = aluSra;
                    aluA = shamtExt;
                end
                fnSllv:  aluOp = aluSll;
                fnSrlv:  aluOp = aluSrl;
                fnSrav:  aluOp = aluSra;
                fnAddu:  aluOp = aluAdd;
                fnSubu:  aluOp = aluSub;
                fnAnd:   aluOp = aluAnd;
                fnOr:    aluOp = aluOr;
                fnXor:   aluOp = aluXor;
                fnSlt:   aluOp = aluSlt;
                fnSltu:  aluOp = aluSltu;
                fnMfhi:  outSel = selHi;
                fnMflo:  outSel = selLo;
                fnMthi: begin
                    mdCmd = mdMthi;
                    outSel = selZero;
                end
                fnMtlo: begin
                    mdCmd = mdMtlo;
                    outSel = selZero;
                end
                fnMult: begin
                    mdCmd = mdMult;
                    outSel = selZero;
                end
                fnMultu: begin
                    mdCmd = mdMultu;
                    outSel = selZero;
                end
                fnDiv: begin
                    mdCmd = mdDiv;
                    outSel = selZero;
                end
                fnDivu: begin
                    mdCmd = mdDivu;
                    outSel = selZero;
                end
                default: outSel = selZero;
            endcase
        end
    end

    always_comb begin
        case (outSel)
            selAlu:  out = aluResult;
            selHi:   out = hi;
            selLo:   out = lo;
            default: out = '0;
        endcase
        // nothing valid leaves the stage while it is held
        if (stall) begin
            out = '0;
        end
    end

    aluCore alu (
        .aluOp  (aluOp),
        .a      (aluA),
        .b      (req.srcB),
        .result (aluResult)
    );

    mulDivUnit mulDiv (
        .clk   (clk),
        .reset (reset),
        .cmd   (mdCmd),
        .srcA  (req.srcA),
        .srcB  (req.srcB),
        .hi    (hi),
        .lo    (lo),
        .stall (stall)
    );

endmodule

`default_nettype wire

/* list.f */
mipsExecPkg.sv
aluCore.sv
multiplier.sv
divider.sv
mulDivUnit.sv
execUnit.sv
execChecker.sv
execTb.sv

/* mipsExecPkg.sv */
`default_nettype none

package mipsExecPkg;

    // ALU control codes from the main decoder
    localparam logic [4:0] aluAnd   = 5'd0;
    localparam logic [4:0] aluOr    = 5'd1;
    localparam logic [4:0] aluAdd   = 5'd2;
    localparam logic [4:0] aluXor   = 5'd3;
    localparam logic [4:0] aluSll   = 5'd4;
    localparam logic [4:0] aluSrl   = 5'd5;
    localparam logic [4:0] aluSub   = 5'd6;
    localparam logic [4:0] aluSlt   = 5'd7;
    localparam logic [4:0] aluSra   = 5'd8;
    localparam logic [4:0] aluSltu  = 5'd9;
    // decode the funct field instead
    localparam logic [4:0] aluRType = 5'd15;

    // R-type function field values
    localparam logic [5:0] fnSll   = 6'h00;
    localparam logic [5:0] fnSrl   = 6'h02;
    localparam logic [5:0] fnSra   = 6'h03;
    localparam logic [5:0] fnSllv  = 6'h04;
    localparam logic [5:0] fnSrlv  = 6'h06;
    localparam logic [5:0] fnSrav  = 6'h07;
    localparam logic [5:0] fnMfhi  = 6'h10;
    localparam logic [5:0] fnMthi  = 6'h11;
    localparam logic [5:0] fnMflo  = 6'h12;
    localparam logic [5:0] fnMtlo  = 6'h13;
    localparam logic [5:0] fnMult  = 6'h18;
    localparam logic [5:0] fnMultu = 6'h19;
    localparam logic [5:0] fnDiv   = 6'h1a;
    localparam logic [5:0] fnDivu  = 6'h1b;
    localparam logic [5:0] fnAddu  = 6'h21;
    localparam logic [5:0] fnSubu  = 6'h23;
    localparam logic [5:0] fnAnd   = 6'h24;
    localparam logic [5:0] fnOr    = 6'h25;
    localparam logic [5:0] fnXor   = 6'h26;
    localparam logic [5:0] fnSlt   = 6'h2a;
    localparam logic [5:0] fnSltu  = 6'h2b;

    // command from the decode logic to the Hi/Lo unit
    typedef logic [2:0] mdCmd_t;

    localparam mdCmd_t mdNone  = 3'd0;
    localparam mdCmd_t mdMult  = 3'd1;
    localparam mdCmd_t mdMultu = 3'd2;
    localparam mdCmd_t mdDiv   = 3'd3;
    localparam mdCmd_t mdDivu  = 3'd4;
    localparam mdCmd_t mdMthi  = 3'd5;
    localparam mdCmd_t mdMtlo  = 3'd6;

    // full stage input
    typedef struct packed {
        logic [4:0]  aluControl;
        logic [5:0]  funct;
        logic [4:0]  shamt;
        logic [31:0] srcA;
        logic [31:0] srcB;
    } execReq_t;

    typedef struct packed {
        logic [31:0] srcA;
        logic [31:0] srcB;
        logic        isSigned;
    } mdOperands_t;

    // product halves, or remainder in hi and quotient in lo
    typedef struct packed {
        logic [31:0] hi;
        logic [31:0] lo;
    } mdResult_t;

endpackage

`default_nettype wire

/* mulDivUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module mulDivUnit import mipsExecPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  mdCmd_t      cmd,
    input  logic [31:0] srcA,
    input  logic [31:0] srcB,
    output logic [31:0] hi,
    output logic [31:0] lo,
    output logic        stall
);

    typedef enum logic [1:0] {seqIdle, seqBusy, seqDone} seqState_t;

    seqState_t   state;
    logic        mulReq;
    logic        divReq;
    logic        mulAck;
    logic        divAck;
    logic        useDiv;
    logic        isMulCmd;
    logic        isDivCmd;
    logic        engAck;
    mdOperands_t operands;
    mdResult_t   mulResult;
    mdResult_t   divResult;
    mdResult_t   engResult;

    assign isMulCmd = (cmd == mdMult) || (cmd == mdMultu);
    assign isDivCmd = (cmd == mdDiv) || (cmd == mdDivu);

    // both engines see the same operands, only one gets req
    assign operands.srcA = srcA;
    assign operands.srcB = srcB;
    assign operands.isSigned = (cmd == mdMult) || (cmd == mdDiv);

    assign engAck = useDiv ? divAck : mulAck;
    assign engResult = useDiv ? divResult : mulResult;

    // low in done, so the pipeline moves on once Hi/Lo hold the result
    assign stall = (state == seqBusy) || (state == seqIdle && (isMulCmd || isDivCmd));

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= seqIdle;
            mulReq <= 1'b0;
            divReq <= 1'b0;
            useDiv <= 1'b0;
            hi <= '0;
            lo <= '0;
        end else begin
            case (state)
                seqIdle: begin
                    if (isMulCmd || isDivCmd) begin
                        state <= seqBusy;
                        useDiv <= isDivCmd;
                        mulReq <= isMulCmd;
                        divReq <= isDivCmd;
                    end else if (cmd == mdMthi) begin
                        hi <= srcA;
                    end else if (cmd == mdMtlo) begin
                        lo <= srcA;
                    end
                end
                seqBusy: begin
                    if (engAck) begin
                        hi <= engResult.hi;
                        lo <= engResult.lo;
                        mulReq <= 1'b0;
                        divReq <= 1'b0;
                        state <= seqDone;
                    end
                end
                default: begin
                    // engine drops ack on this same edge
                    state <= seqIdle;
                end
            endcase
        end
    end

    multiplier mulEngine (
        .clk      (clk),
        .reset    (reset),
        .req      (mulReq),
        .ack      (mulAck),
        .operands (operands),
        .product  (mulResult)
    );

    divider divEngine (
        .clk      (clk),
        .reset    (reset),
        .req      (divReq),
        .ack      (divAck),
        .operands (operands),
        .quotient (divResult)
    );

endmodule

`default_nettype wire

/* multiplier.sv */
`timescale 1ns/1ps
`default_nettype none

module multiplier import mipsExecPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        req,
    output logic        ack,
    input  mdOperands_t operands,
    output mdResult_t   product
);

    typedef enum logic [1:0] {mulIdle, mulRun, mulFix, mulDone} mulState_t;

    mulState_t   state;
    logic [4:0]  count;
    logic [31:0] magA;
    logic [63:0] acc;
    logic        negate;
    logic [32:0] partial;

    // add the multiplicand into the upper half when the low bit is set
    assign partial = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, magA} : 33'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mulIdle;
            count <= '0;
            ack <= 1'b0;
        end else begin
            case (state)
                mulIdle: begin
                    if (req && !ack) begin
                        state <= mulRun;
                        count <= '0;
                    end
                end
                mulRun: begin
                    count <= count + 5'd1;
                    if (count == 5'd31) begin
                        state <= mulFix;
                    end
                end
                mulFix: begin
                    state <= mulDone;
                    ack <= 1'b1;
                end
                default: begin
                    // hold the product until the sequencer lets go
                    if (!req) begin
                        state <= mulIdle;
                        ack <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mulIdle && req && !ack) begin
            magA <= (operands.isSigned && operands.srcA[31]) ? -operands.srcA : operands.srcA;
            acc <= {32'd0, (operands.isSigned && operands.srcB[31]) ?
                           -operands.srcB : operands.srcB};
            negate <= operands.isSigned && (operands.srcA[31] ^ operands.srcB[31]);
        end else if (state == mulRun) begin
            acc <= {partial, acc[31:1]};
        end else if (state == mulFix) begin
            product <= negate ? (~acc + 64'd1) : acc;
        end
    end

endmodule

`default_nettype wire
